// File: Makefile
# Verilator simulation of the key store
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build and run the simulation, then check the log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --assert -Wno-fatal --top-module tb_key_store -f list.f -o tb_key_store
	./obj_dir/tb_key_store +verilator+error+limit+100 | tee $(LOG)
	grep -q "Finished with no errors" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: list.f
source/mem_map_pkg.sv
source/uart_pkg.sv
source/uart_rx.sv
source/word_assembler.sv
source/region_loader.sv
source/key_memory.sv
source/dump_sequencer.sv
source/uart_tx.sv
source/key_store_top.sv
verif/key_store_checker.sv
verif/tb_key_store.sv

// File: source/dump_sequencer.sv
`timescale 1ns/1ps

module dump_sequencer import mem_map_pkg::*; (
   input  logic                       clk_100mhz,
   input  logic                       sys_rst,
   input  logic                       dump_en,
   input  logic                       tx_busy,
   output logic [word_addr_width-1:0] rd_addr,
   input  key_word_u                  rd_data,
   output logic [7:0]                 tx_byte,
   output logic                       tx_start,
   output logic                       dump_done
);

   logic [1:0] byte_idx;
   logic       all_sent;
   logic       tx_free;

   assign all_sent = rd_addr == word_addr_width'(total_words);

   // no back to back starts since busy only shows a cycle later
   assign tx_free = !tx_busy && !tx_start;

   always_ff @(posedge clk_100mhz) begin
      if (sys_rst || !dump_en) begin
         rd_addr   <= '0;
         byte_idx  <= 2'd0;
         tx_start  <= 1'b0;
         dump_done <= 1'b0;
      end else begin
         tx_start <= 1'b0;
         if (all_sent) begin
            if (tx_free) dump_done <= 1'b1;  // last frame is out
         end else if (tx_free) begin
            // read data settles well within a 100 clock frame
            tx_byte  <= rd_data.bytes[byte_idx];
            tx_start <= 1'b1;
            byte_idx <= byte_idx + 2'd1;
            if (byte_idx == 2'd3) rd_addr <= rd_addr + 1'b1;
         end
      end
   end

endmodule

// File: source/key_memory.sv
`timescale 1ns/1ps

module key_memory import mem_map_pkg::*; (
   input  logic                       clk_100mhz,
   input  logic                       wr_en,
   input  region_e                    wr_region,
   input  logic [word_addr_width-1:0] wr_addr,    // local index
   input  key_word_u                  wr_data,
   input  logic [word_addr_width-1:0] rd_addr,    // global address
   output key_word_u                  rd_data
);

   logic [word_width-1:0] mem_a  [a_depth];
   logic [pt_width-1:0]   mem_pt [pt_depth];
   logic [sk_width-1:0]   mem_sk [sk_depth];
   logic [word_width-1:0] mem_b  [b_depth];

   logic [word_addr_width-1:0] rd_addr_q;
   logic [word_addr_width-1:0] rd_local;
   region_e                    rd_region;

   always_ff @(posedge clk_100mhz) begin
      if (wr_en) begin
         case (wr_region)
            region_a:  mem_a[wr_addr[a_idx_width-1:0]] <= wr_data.word;
            region_pt: mem_pt[wr_addr[pt_idx_width-1:0]] <= wr_data.word[pt_width-1:0];
            region_sk: mem_sk[wr_addr[sk_idx_width-1:0]] <= wr_data.word[sk_width-1:0];
            region_b:  mem_b[wr_addr[b_idx_width-1:0]] <= wr_data.word;
         endcase
      end
   end

   assign rd_region = addr_region(rd_addr_q);
   assign rd_local  = addr_local(rd_addr_q);

   // stage 1 address register, stage 2 output register
   always_ff @(posedge clk_100mhz) begin
      rd_addr_q <= rd_addr;
      case (rd_region)
         region_a:  rd_data.word <= mem_a[rd_local[a_idx_width-1:0]];
         region_pt: rd_data.word <= word_width'(mem_pt[rd_local[pt_idx_width-1:0]]);
         region_sk: rd_data.word <= word_width'(mem_sk[rd_local[sk_idx_width-1:0]]);
         region_b:  rd_data.word <= mem_b[rd_local[b_idx_width-1:0]];
      endcase
   end

endmodule

// File: source/key_store_top.sv
`timescale 1ns/1ps

module key_store_top import uart_pkg::*, mem_map_pkg::*; (
   input  logic clk_100mhz,
   input  logic sys_rst,
   input  logic uart_rxd,
   input  logic dump_en,
   output logic uart_txd,
   output logic dump_done
);

   rx_byte_t                   rx;
   logic                       word_valid;
   key_word_u                  word;

   // load path into the region memories
   logic                       wr_en;
   region_e                    wr_region;
   logic [word_addr_width-1:0] wr_addr;
   key_word_u                  wr_data;

   // dump path
   logic [word_addr_width-1:0] rd_addr;
   key_word_u                  rd_data;
   logic [7:0]                 tx_byte;
   logic                       tx_start;
   logic                       tx_busy;

   uart_rx u_uart_rx (
      .clk_100mhz (clk_100mhz),
      .sys_rst    (sys_rst),
      .uart_rxd   (uart_rxd),
      .rx         (rx)
   );

   word_assembler u_word_assembler (
      .clk_100mhz (clk_100mhz),
      .sys_rst    (sys_rst),
      .rx         (rx),
      .word_valid (word_valid),
      .word       (word)
   );

   region_loader u_region_loader (
      .clk_100mhz (clk_100mhz),
      .sys_rst    (sys_rst),
      .word_valid (word_valid),
      .word       (word),
      .wr_en      (wr_en),
      .wr_region  (wr_region),
      .wr_addr    (wr_addr),
      .wr_data    (wr_data)
   );

   key_memory u_key_memory (
      .clk_100mhz (clk_100mhz),
      .wr_en      (wr_en),
      .wr_region  (wr_region),
      .wr_addr    (wr_addr),
      .wr_data    (wr_data),
      .rd_addr    (rd_addr),
      .rd_data    (rd_data)
   );

   dump_sequencer u_dump_sequencer (
      .clk_100mhz (clk_100mhz),
      .sys_rst    (sys_rst),
      .dump_en    (dump_en),
      .tx_busy    (tx_busy),
      .rd_addr    (rd_addr),
      .rd_data    (rd_data),
      .tx_byte    (tx_byte),
      .tx_start   (tx_start),
      .dump_done  (dump_done)
   );

   uart_tx u_uart_tx (
      .clk_100mhz (clk_100mhz),
      .sys_rst    (sys_rst),
      .tx_byte    (tx_byte),
      .tx_start   (tx_start),
      .tx_busy    (tx_busy),
      .uart_txd   (uart_txd)
   );

endmodule

// File: source/mem_map_pkg.sv
package mem_map_pkg;
   localparam int word_width = 32;
   localparam int a_depth = 8;     // public matrix A
   localparam int pt_depth = 4;    // plaintext noise
   localparam int sk_depth = 4;    // secret key
   localparam int b_depth = 4;     // public vector b
   localparam int total_words = a_depth + pt_depth + sk_depth + b_depth;
   localparam int word_addr_width = $clog2(total_words + 1);

   // local index widths per region
   localparam int a_idx_width = $clog2(a_depth);
   localparam int pt_idx_width = $clog2(pt_depth);
   localparam int sk_idx_width = $clog2(sk_depth);
   localparam int b_idx_width = $clog2(b_depth);

   localparam int pt_width = 2;
   localparam int sk_width = 2;

   // global word address where each region starts with A at 0
   localparam logic [word_addr_width-1:0] pt_base = word_addr_width'(a_depth);
   localparam logic [word_addr_width-1:0] sk_base = pt_base + word_addr_width'(pt_depth);
   localparam logic [word_addr_width-1:0] b_base = sk_base + word_addr_width'(sk_depth);

   // uart side sees bytes and memory side sees words
   typedef union packed {
      logic [word_width-1:0] word;
      logic [3:0][7:0]       bytes;  // bytes[0] is the lsb
   } key_word_u;

   typedef enum logic [1:0] {region_a, region_pt, region_sk, region_b} region_e;

   function automatic region_e addr_region(input logic [word_addr_width-1:0] addr);
      if (addr < pt_base) return region_a;
      if (addr < sk_base) return region_pt;
      if (addr < b_base) return region_sk;
      return region_b;
   endfunction

   // global address to index inside its region
   function automatic logic [word_addr_width-1:0] addr_local(
      input logic [word_addr_width-1:0] addr
   );
      case (addr_region(addr))
         region_pt: return addr - pt_base;
         region_sk: return addr - sk_base;
         region_b:  return addr - b_base;
         default:   return addr;
      endcase
   endfunction
endpackage

// File: source/region_loader.sv
`timescale 1ns/1ps

module region_loader import mem_map_pkg::*; (
   input  logic                       clk_100mhz,
   input  logic                       sys_rst,
   input  logic                       word_valid,
   input  key_word_u                  word,
   output logic                       wr_en,
   output region_e                    wr_region,
   output logic [word_addr_width-1:0] wr_addr,
   output key_word_u                  wr_data
);

   logic [word_addr_width-1:0] load_cnt;
   logic                       load_ok;

   // count stops at total_words and later words are dropped
   assign load_ok = load_cnt < word_addr_width'(total_words);

   always_ff @(posedge clk_100mhz) begin
      if (sys_rst) begin
         load_cnt <= '0;
         wr_en    <= 1'b0;
      end else begin
         wr_en <= word_valid && load_ok;
         if (word_valid && load_ok) begin
            load_cnt  <= load_cnt + 1'b1;
            wr_region <= addr_region(load_cnt);
            wr_addr   <= addr_local(load_cnt);
            wr_data   <= word;
         end
      end
   end

endmodule

// File: source/uart_pkg.sv
package uart_pkg;
   // 100 MHz clock at 10 Mbaud
   localparam int clks_per_bit = 10;
   localparam int baud_cnt_width = $clog2(clks_per_bit);

   // counter value on the last clock of a bit
   localparam logic [baud_cnt_width-1:0] baud_last = baud_cnt_width'(clks_per_bit - 1);

   // counter value near the middle of the start bit
   localparam logic [baud_cnt_width-1:0] baud_half = baud_cnt_width'(clks_per_bit / 2 - 1);

   typedef struct packed {
      logic       valid;  // one cycle per byte
      logic [7:0] data;
   } rx_byte_t;
endpackage

// File: source/uart_rx.sv
`timescale 1ns/1ps

module uart_rx import uart_pkg::*; (
   input  logic     clk_100mhz,
   input  logic     sys_rst,
   input  logic     uart_rxd,
   output rx_byte_t rx
);

   logic [1:0]                rx_sync;
   logic                      rx_line;
   logic                      active;
   logic [3:0]                bit_idx;   // 0 start, 1 to 8 data, 9 stop
   logic [baud_cnt_width-1:0] baud_cnt;

   assign rx_line = rx_sync[1];

   always_ff @(posedge clk_100mhz) begin
      if (sys_rst) begin
         rx_sync  <= 2'b11;  // line idles high
         active   <= 1'b0;
         bit_idx  <= 4'd0;
         baud_cnt <= '0;
         rx.valid <= 1'b0;
      end else begin
         rx_sync  <= {rx_sync[0], uart_rxd};
         rx.valid <= 1'b0;
         if (!active) begin
            if (!rx_line) begin   // falling edge may be a start bit
               active   <= 1'b1;
               bit_idx  <= 4'd0;
               baud_cnt <= '0;
            end
         end else if (bit_idx == 4'd0) begin
            if (baud_cnt == baud_half) begin
               baud_cnt <= '0;
               if (rx_line) begin
                  active <= 1'b0;   // only a glitch so back to idle
               end else begin
                  bit_idx <= 4'd1;
               end
            end else begin
               baud_cnt <= baud_cnt + 1'b1;
            end
         end else if (baud_cnt == baud_last) begin
            // middle of a data or stop bit
            baud_cnt <= '0;
            bit_idx  <= bit_idx + 4'd1;
            if (bit_idx == 4'd9) begin
               active   <= 1'b0;
               rx.valid <= rx_line;  // drop framing errors
            end else begin
               rx.data <= {rx_line, rx.data[7:1]};  // lsb first
            end
         end else begin
            baud_cnt <= baud_cnt + 1'b1;
         end
      end
   end

endmodule

// File: source/uart_tx.sv
`timescale 1ns/1ps

module uart_tx import uart_pkg::*; (
   input  logic       clk_100mhz,
   input  logic       sys_rst,
   input  logic [7:0] tx_byte,
   input  logic       tx_start,
   output logic       tx_busy,
   output logic       uart_txd
);

   logic [8:0]                shifter;   // data bits then stop bit
   logic [3:0]                bit_cnt;
   logic [baud_cnt_width-1:0] baud_cnt;

   always_ff @(posedge clk_100mhz) begin
      if (sys_rst) begin
         tx_busy  <= 1'b0;
         uart_txd <= 1'b1;
         bit_cnt  <= 4'd0;
         baud_cnt <= '0;
      end else if (!tx_busy) begin
         if (tx_start) begin
            shifter  <= {1'b1, tx_byte};
            uart_txd <= 1'b0;  // start bit
            tx_busy  <= 1'b1;
            bit_cnt  <= 4'd0;
            baud_cnt <= '0;
         end
      end else if (baud_cnt == baud_last) begin
         baud_cnt <= '0;
         if (bit_cnt == 4'd9) begin
            tx_busy  <= 1'b0;   // stop bit done
            uart_txd <= 1'b1;
         end else begin
            uart_txd <= shifter[0];
            shifter  <= {1'b1, shifter[8:1]};
            bit_cnt  <= bit_cnt + 4'd1;
         end
      end else begin
         baud_cnt <= baud_cnt + 1'b1;
      end
   end

endmodule

// File: source/word_assembler.sv
`timescale 1ns/1ps

module word_assembler import uart_pkg::*, mem_map_pkg::*; (
   input  logic      clk_100mhz,
   input  logic      sys_rst,
   input  rx_byte_t  rx,
   output logic      word_valid,
   output key_word_u word
);

   logic [1:0] lane;  // next byte lane to fill

   always_ff @(posedge clk_100mhz) begin
      if (sys_rst) begin
         lane       <= 2'd0;
         word_valid <= 1'b0;
      end else begin
         word_valid <= 1'b0;
         if (rx.valid) begin
            word.bytes[lane] <= rx.data;
            lane             <= lane + 2'd1;   // wraps back to lane 0
            if (lane == 2'd3) word_valid <= 1'b1;
         end
      end
   end

endmodule

// File: verif/key_store_checker.sv
`timescale 1ns/1ps

module key_store_checker (
   input logic clk_100mhz,
   input logic sys_rst,
   input logic dump_en,
   input logic uart_txd,
   input logic dump_done,
   input logic tx_start,
   input logic tx_busy
);

   int unsigned fail_cnt = 0;  // failed assertions so far

   // line idles high and nothing is done yet
   idle_after_reset: assert property (@(posedge clk_100mhz)
      sys_rst |=> uart_txd && !dump_done)
      else begin
         $error("uart_txd low or dump_done high right after reset");
         fail_cnt++;
      end

   no_start_while_busy: assert property (@(posedge clk_100mhz) disable iff (sys_rst)
      !(tx_start && tx_busy))
      else begin
         $error("tx_start issued while the transmitter was busy");
         fail_cnt++;
      end

   done_clears: assert property (@(posedge clk_100mhz) disable iff (sys_rst)
      $fell(dump_en) |=> !dump_done)
      else begin
         $error("dump_done still high a cycle after dump_en fell");
         fail_cnt++;
      end

endmodule

bind key_store_top key_store_checker u_checker (
   .clk_100mhz (clk_100mhz),
   .sys_rst    (sys_rst),
   .dump_en    (dump_en),
   .uart_txd   (uart_txd),
   .dump_done  (dump_done),
   .tx_start   (tx_start),
   .tx_busy    (tx_busy)
);

// File: verif/tb_key_store.sv
`timescale 1ns/1ps

module tb_key_store import uart_pkg::*, mem_map_pkg::*; ();

   localparam int frame_clks = 10 * clks_per_bit;   // start, 8 data, stop
   localparam int dump_bytes = 4 * total_words;
   // three phases of load, first dump and extra words with second dump
   localparam int watchdog_ns = (total_words + 2) * 4 * frame_clks * 10 * 3 + 20000;

   logic clk_100mhz;
   logic sys_rst;
   logic uart_rxd;
   logic dump_en;
   logic uart_txd;
   logic dump_done;

   logic [31:0] ref_words [total_words];
   logic [7:0]  first_bytes [dump_bytes];   // kept for the restart compare
   logic [31:0] rng = 32'd4;
   int          err_cnt [1:5];

   key_store_top u_dut (.*);

   initial begin
      clk_100mhz = 1'b0;
      forever #5 clk_100mhz = ~clk_100mhz;
   end

   initial begin
      #watchdog_ns;
      $display("watchdog expired after %0d ns, the run did not complete", watchdog_ns);
      $display("Finished with errors");
      $finish;
   end

   function automatic logic [31:0] xorshift(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      return y ^ (y << 5);
   endfunction

   // pt and sk hold only their low bits
   function automatic logic [31:0] model_word(input int idx, input logic [31:0] w);
      if (idx >= int'(b_base)) return w;
      if (idx >= int'(sk_base)) return 32'(w[sk_width-1:0]);
      if (idx >= int'(pt_base)) return 32'(w[pt_width-1:0]);
      return w;
   endfunction

   task automatic send_byte(input logic [7:0] data);
      logic [9:0] frame;
      frame = {1'b1, data, 1'b0};   // stop, data, start
      for (int i = 0; i < 10; i++) begin
         @(negedge clk_100mhz);
         uart_rxd = frame[i];
         repeat (clks_per_bit - 1) @(negedge clk_100mhz);
      end
   endtask

   task automatic send_word(input logic [31:0] w);
      for (int k = 0; k < 4; k++) send_byte(w[8*k +: 8]);   // lsb first
   endtask

   // samples the middle of each bit
   task automatic recv_byte(output logic [7:0] data, output logic stop_ok);
      data = '0;
      @(negedge clk_100mhz);
      while (uart_txd !== 1'b0) @(negedge clk_100mhz);
      repeat (clks_per_bit / 2) @(negedge clk_100mhz);
      for (int i = 0; i < 8; i++) begin
         repeat (clks_per_bit) @(negedge clk_100mhz);
         data[i] = uart_txd;
      end
      repeat (clks_per_bit) @(negedge clk_100mhz);
      stop_ok = uart_txd;
   endtask

   task automatic run_dump(input bit second);
      logic [7:0] got;
      logic [7:0] exp;
      logic       stop_ok;
      int         t;
      int         cyc;
      @(negedge clk_100mhz);
      dump_en = 1'b1;
      for (int i = 0; i < dump_bytes; i++) begin
         recv_byte(got, stop_ok);
         exp = ref_words[i / 4][8 * (i % 4) +: 8];
         t = (i / 4 >= int'(pt_base) && i / 4 < int'(b_base)) ? 3 : 2;
         if (second) t = 4;   // extra words must not show up
         assert (got === exp) else begin
            $display("[ERROR] %0t uart_txd byte %0d: expected %02h, got %02h",
                     $time, i, exp, got);
            err_cnt[t]++;
         end
         assert (stop_ok === 1'b1) else begin
            $display("byte %0d was sent without a valid stop bit", i);
            err_cnt[t]++;
         end
         if (second) begin
            assert (got === first_bytes[i]) else begin
               $display("[ERROR] %0t uart_txd restart byte %0d: expected %02h, got %02h",
                        $time, i, first_bytes[i], got);
               err_cnt[5]++;
            end
         end else begin
            first_bytes[i] = got;
         end
         assert (dump_done === 1'b0) else begin
            $display("dump_done rose after only %0d bytes", i + 1);
            err_cnt[5]++;
         end
      end
      cyc = 0;
      while (dump_done !== 1'b1 && cyc < frame_clks) begin
         @(negedge clk_100mhz);
         cyc++;
      end
      assert (dump_done === 1'b1) else begin
         $display("dump_done never rose after the last byte");
         err_cnt[5]++;
      end
   endtask

   task automatic report_test(input int n, input string name);
      $display("test %0d %s: %0d errors", n, name, err_cnt[n]);
   endtask

   initial begin
      int tb_errs;
      uart_rxd = 1'b1;
      dump_en  = 1'b0;
      sys_rst  = 1'b1;
      foreach (err_cnt[n]) err_cnt[n] = 0;
      repeat (4) @(negedge clk_100mhz);
      sys_rst = 1'b0;

      repeat (2 * frame_clks) begin
         @(negedge clk_100mhz);
         assert (uart_txd === 1'b1 && dump_done === 1'b0) else begin
            $display("[ERROR] %0t uart_txd/dump_done: expected 1/0, got %b/%b",
                     $time, uart_txd, dump_done);
            err_cnt[1]++;
         end
      end
      report_test(1, "idle outputs after reset");

      for (int i = 0; i < total_words; i++) begin
         rng = xorshift(rng);
         ref_words[i] = model_word(i, rng);
         send_word(rng);
      end
      repeat (10) @(negedge clk_100mhz);   // last write lands
      run_dump(1'b0);
      report_test(2, "A and b read back");
      report_test(3, "pt and sk read back masked");

      @(negedge clk_100mhz);
      dump_en = 1'b0;
      repeat (2) @(negedge clk_100mhz);
      assert (dump_done === 1'b0) else begin
         $display("[ERROR] %0t dump_done: expected 0, got %b", $time, dump_done);
         err_cnt[5]++;
      end
      for (int i = 0; i < 2; i++) begin
         rng = xorshift(rng);
         send_word(rng);
      end
      repeat (10) @(negedge clk_100mhz);
      run_dump(1'b1);
      report_test(4, "words past the end ignored");
      report_test(5, "dump_done and restart");

      tb_errs = 0;
      foreach (err_cnt[n]) tb_errs += err_cnt[n];
      $display("5 tests, %0d check errors, %0d assertion failures",
               tb_errs, u_dut.u_checker.fail_cnt);
      if (tb_errs == 0 && u_dut.u_checker.fail_cnt == 0) begin
         $display("Finished with no errors");
      end else begin
         $display("Finished with errors");
      end
      $finish;
   end

endmodule
